// ==== sim.f ====
design/bd_pkg.sv
design/bd_led_blinker.sv
design/bd_mode_ctrl.sv
design/bd_temp_reader.sv
design/bd_temp_monitor.sv
design/bd_supervisor_top.sv
dv/bd_sensor_model.sv
dv/bd_supervisor_asserts.sv
dv/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the supervisor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_top -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, pass message not found in $LOG"
exit 1

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

    import bd_pkg::*;

    localparam int BLINK_HALF      = 8;
    localparam int SAMPLE_INTERVAL = 200;
    localparam int SPI_DIV         = 2;
    localparam int CYCLE_LIMIT     = 20000;
    localparam int READ_TIMEOUT    = 2 * SAMPLE_INTERVAL;

    logic     MCLK;
    logic     MRST;
    logic     usb_pwr;
    logic     board_pwr_fail;
    temp_sw_t temp_sw;
    logic     force_start;
    logic     temp_sio;
    logic     temp_cs_n;
    logic     temp_sclk;
    logic     emu_en;
    logic     usb_en;
    logic     emu_ready;
    logic     temp_lo_n;
    logic     fan_en_n;
    led_bus_t leds;
    temp_t    sensor_temp;

    int       seed      = 8147;
    int       cycle_cnt = 0;

    bd_supervisor_top
    #(
        .BLINK_HALF      (BLINK_HALF),
        .SAMPLE_INTERVAL (SAMPLE_INTERVAL),
        .SPI_DIV         (SPI_DIV)
    )
    i_dut
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .usb_pwr        (usb_pwr),
        .board_pwr_fail (board_pwr_fail),
        .temp_sw        (temp_sw),
        .force_start    (force_start),
        .temp_sio       (temp_sio),
        .temp_cs_n      (temp_cs_n),
        .temp_sclk      (temp_sclk),
        .emu_en         (emu_en),
        .usb_en         (usb_en),
        .emu_ready      (emu_ready),
        .temp_lo_n      (temp_lo_n),
        .fan_en_n       (fan_en_n),
        .leds           (leds)
    );

    bd_sensor_model i_sensor
    (
        .cs_n (temp_cs_n),
        .sclk (temp_sclk),
        .temp (sensor_temp),
        .sio  (temp_sio)
    );

    bind bd_supervisor_top bd_supervisor_asserts i_asserts
    (
        .MCLK      (MCLK),
        .MRST      (MRST),
        .rd_req    (rd_req),
        .rd_ack    (rd_ack),
        .temp_cs_n (temp_cs_n),
        .temp_sclk (temp_sclk),
        .emu_en    (emu_en),
        .emu_ready (emu_ready),
        .leds      (leds)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #10 MCLK = ~MCLK;
    end

    always @(posedge MCLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout, the test sequence did not finish in %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    always @(negedge MCLK)
    begin
        if (i_dut.i_asserts.any_fail)
        begin
            $display("a bound protocol assertion failed at %0t", $time);
            $display("TEST FAILED");
            $fatal(1, "bound assertion failure");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks and sequences

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // reset with the supply inputs applied and wait for the mode outputs
    task automatic start_mode(input logic usb, input logic fail);
        @(negedge MCLK);
        MRST           = 1'b1;
        usb_pwr        = usb;
        board_pwr_fail = fail;
        force_start    = 1'b0;
        repeat (3) @(negedge MCLK);
        MRST = 1'b0;
        // select, mode, then registered outputs
        repeat (3) @(negedge MCLK);
    endtask

    task automatic expect_mode(input logic usb, input logic fail);
        logic emulate;
        logic standby;
        emulate = !usb && !fail;
        standby = usb && fail;
        check_bit("emu_en", emu_en, emulate);
        check_bit("usb_en", usb_en, emulate || standby);
        check_bit("emu_ready", emu_ready, 1'b0);
        check_bit("temp_lo_n", temp_lo_n, 1'b1);
        check_bit("fan_en_n", fan_en_n, 1'b1);
        // no reading yet, so emulate still warms up
        check_bit("leds.led_delaying_n", leds.led_delaying_n, !emulate);
        check_bit("leds.led_standby_n", leds.led_standby_n, !emulate);
        check_bit("leds.led_pwrok_n", leds.led_pwrok_n, 1'b1);
        check_bit("leds.led_acc_n", leds.led_acc_n, 1'b1);
    endtask

    // flashing leds start dark and invert every half period
    task automatic watch_blink(input logic pwrok_flash, input logic standby_flash,
                               input int cycles);
        logic lit_phase;
        for (int k = 1; k <= cycles; k++)
        begin
            @(negedge MCLK);
            lit_phase = ((k / BLINK_HALF) % 2) == 1;
            check_bit("leds.led_pwrok_n", leds.led_pwrok_n, !(pwrok_flash && lit_phase));
            check_bit("leds.led_standby_n", leds.led_standby_n,
                      !(standby_flash && lit_phase));
        end
    endtask

    task automatic wait_ack(input logic level);
        int waited;
        waited = 0;
        while (i_dut.rd_ack !== level)
        begin
            @(negedge MCLK);
            waited++;
            if (waited > READ_TIMEOUT)
            begin
                $display("no sensor read handshake within %0d cycles", READ_TIMEOUT);
                $display("TEST FAILED");
                $fatal(1, "handshake timeout");
            end
        end
    endtask

    // threshold is 5 degrees per switch step and the fan starts at 40 degrees
    task automatic compare_reading(input int value);
        int   thr;
        logic lo;
        logic hot;
        thr = int'(temp_sw) * 5 * 16;
        lo  = value < thr;
        hot = value >= 40 * 16;
        check_bit("temp_lo_n", temp_lo_n, !lo);
        check_bit("fan_en_n", fan_en_n, !hot);
        check_bit("emu_ready", emu_ready, !lo);
        check_bit("leds.led_delaying_n", leds.led_delaying_n, !lo);
        check_bit("leds.led_standby_n", leds.led_standby_n, !lo);
    endtask

    task automatic read_and_check(input int sw, input int value);
        temp_sw     = temp_sw_t'(sw);
        sensor_temp = temp_t'(value);
        wait_ack(1'b1);
        wait_ack(1'b0);
        compare_reading(value);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial
    begin
        MRST           = 1'b1;
        usb_pwr        = 1'b0;
        board_pwr_fail = 1'b0;
        temp_sw        = 3'd0;
        force_start    = 1'b0;
        sensor_temp    = '0;

        // mode table and blinking in the flashing modes
        start_mode(1'b0, 1'b0);
        expect_mode(1'b0, 1'b0);
        start_mode(1'b0, 1'b1);
        expect_mode(1'b0, 1'b1);
        watch_blink(1'b1, 1'b0, 40);
        start_mode(1'b1, 1'b0);
        expect_mode(1'b1, 1'b0);
        watch_blink(1'b0, 1'b1, 40);
        start_mode(1'b1, 1'b1);
        expect_mode(1'b1, 1'b1);
        watch_blink(1'b1, 1'b1, 40);

        // exact threshold and fan points
        start_mode(1'b0, 1'b0);
        read_and_check(3, 240);
        read_and_check(3, 239);
        read_and_check(0, 640);
        read_and_check(7, 639);
        read_and_check(0, -1);

        // random readings and switch settings
        repeat (6)
        begin
            start_mode(1'b0, 1'b0);
            repeat (5)
                read_and_check($random(seed) & 7, ($random(seed) & 1023) - 160);
        end

        // cold reading, then force_start skips the warm-up
        start_mode(1'b0, 1'b0);
        read_and_check(7, -100);
        force_start = 1'b1;
        repeat (2) @(negedge MCLK);
        check_bit("emu_ready", emu_ready, 1'b1);
        check_bit("leds.led_delaying_n", leds.led_delaying_n, 1'b1);
        force_start = 1'b0;

        // board power returns while in the error mode
        start_mode(1'b0, 1'b1);
        expect_mode(1'b0, 1'b1);
        board_pwr_fail = 1'b0;
        repeat (5) @(negedge MCLK);
        expect_mode(1'b0, 1'b0);

        @(negedge MCLK);
        if (i_dut.i_asserts.any_fail)
        begin
            $display("a bound protocol assertion failed at %0t", $time);
            $display("TEST FAILED");
            $fatal(1, "bound assertion failure");
        end
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== dv/bd_supervisor_asserts.sv ====
`timescale 1ns/100ps

module bd_supervisor_asserts
(
    input logic             MCLK,
    input logic             MRST,
    input logic             rd_req,
    input logic             rd_ack,
    input logic             temp_cs_n,
    input logic             temp_sclk,
    input logic             emu_en,
    input logic             emu_ready,
    input bd_pkg::led_bus_t leds
);

    logic       sclk_q;
    logic [5:0] sclk_rises;

    // sticky failure flag per property
    bit         ack_err    = 1'b0;
    bit         drop_err   = 1'b0;
    bit         rerise_err = 1'b0;
    bit         frame_err  = 1'b0;
    bit         ready_err  = 1'b0;
    logic       any_fail;

    assign any_fail = ack_err | drop_err | rerise_err | frame_err | ready_err;

    // sclk rising edges seen while cs is low
    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            sclk_q     <= 1'b0;
            sclk_rises <= 6'd0;
        end
        else
        begin
            sclk_q <= temp_sclk;
            if (temp_cs_n)
                sclk_rises <= 6'd0;
            else if (temp_sclk && !sclk_q)
                sclk_rises <= sclk_rises + 6'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // four-phase handshake

    ack_needs_req: assert property (@(posedge MCLK) disable iff (MRST)
        $rose(rd_ack) |-> rd_req)
    else
    begin
        ack_err = 1'b1;
        $error("rd_ack rose while rd_req was low");
    end

    req_holds_for_ack: assert property (@(posedge MCLK) disable iff (MRST)
        $fell(rd_req) |-> $past(rd_ack))
    else
    begin
        drop_err = 1'b1;
        $error("rd_req dropped before rd_ack rose");
    end

    // no new request until the previous ack is gone
    req_waits_ack_low: assert property (@(posedge MCLK) disable iff (MRST)
        $rose(rd_req) |-> !$past(rd_ack))
    else
    begin
        rerise_err = 1'b1;
        $error("rd_req rose while rd_ack was still high");
    end

    //////////////////////////////////////////////////////////////////////
    // serial framing and ready output

    frame_16_clocks: assert property (@(posedge MCLK) disable iff (MRST)
        $rose(temp_cs_n) |-> sclk_rises == 6'd16)
    else
    begin
        frame_err = 1'b1;
        $error("cs window did not hold 16 sclk rising edges");
    end

    // ready only in emulation with the warm-up led dark
    ready_follows_delay: assert property (@(posedge MCLK) disable iff (MRST)
        emu_ready == (emu_en && leds.led_delaying_n))
    else
    begin
        ready_err = 1'b1;
        $error("emu_ready differs from emu_en with the delaying led off");
    end

endmodule

// ==== dv/bd_sensor_model.sv ====
`timescale 1ns/100ps

module bd_sensor_model
(
    input  logic          cs_n,
    input  logic          sclk,
    input  bd_pkg::temp_t temp,
    output logic          sio
);

    // trailing status bits that the reader drops
    localparam logic [2:0] STATUS_BITS = 3'b101;

    logic [15:0] frame;
    logic [3:0]  bit_idx;

    // reading is frozen when the read opens
    always @(negedge cs_n)
    begin
        frame = {temp, STATUS_BITS};
    end

    // next bit goes out on each falling sclk, msb first
    always @(posedge cs_n or negedge sclk)
    begin
        if (cs_n)
            bit_idx = 4'd0;
        else
            bit_idx = bit_idx + 4'd1;
    end

    assign sio = frame[4'd15 - bit_idx];

endmodule

// ==== design/bd_supervisor_top.sv ====
`timescale 1ns/100ps

module bd_supervisor_top
#(
    parameter int BLINK_HALF      = 48000000,
    parameter int SAMPLE_INTERVAL = 4800000,
    parameter int SPI_DIV         = 12
)
(
    input  logic             MCLK,
    input  logic             MRST,
    input  logic             usb_pwr,
    input  logic             board_pwr_fail,
    input  bd_pkg::temp_sw_t temp_sw,
    input  logic             force_start,
    input  logic             temp_sio,
    output logic             temp_cs_n,
    output logic             temp_sclk,
    output logic             emu_en,
    output logic             usb_en,
    output logic             emu_ready,
    output logic             temp_lo_n,
    output logic             fan_en_n,
    output bd_pkg::led_bus_t leds
);

    import bd_pkg::*;

    logic  blink_run;
    logic  blink;
    logic  delaying;
    logic  temp_en;
    logic  rd_req;
    logic  rd_ack;
    temp_t rd_temp;

    //////////////////////////////////////////////////////////////////////
    // mode control and blinker

    // no emulator core here, so the access led stays dark
    bd_mode_ctrl i_mode_ctrl
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .usb_pwr        (usb_pwr),
        .board_pwr_fail (board_pwr_fail),
        .delaying       (delaying),
        .blink          (blink),
        .acc_n          (1'b1),
        .emu_en         (emu_en),
        .usb_en         (usb_en),
        .temp_en        (temp_en),
        .emu_ready      (emu_ready),
        .blink_run      (blink_run),
        .leds           (leds)
    );

    bd_led_blinker #(.BLINK_HALF(BLINK_HALF)) i_led_blinker
    (
        .MCLK  (MCLK),
        .MRST  (MRST),
        .run   (blink_run),
        .blink (blink)
    );

    //////////////////////////////////////////////////////////////////////
    // temperature path

    bd_temp_monitor #(.SAMPLE_INTERVAL(SAMPLE_INTERVAL)) i_temp_monitor
    (
        .MCLK        (MCLK),
        .MRST        (MRST),
        .en          (temp_en),
        .temp_sw     (temp_sw),
        .force_start (force_start),
        .rd_ack      (rd_ack),
        .rd_temp     (rd_temp),
        .rd_req      (rd_req),
        .delaying    (delaying),
        .temp_lo_n   (temp_lo_n),
        .fan_en_n    (fan_en_n)
    );

    bd_temp_reader #(.SPI_DIV(SPI_DIV)) i_temp_reader
    (
        .MCLK    (MCLK),
        .MRST    (MRST),
        .rd_req  (rd_req),
        .sio     (temp_sio),
        .rd_ack  (rd_ack),
        .rd_temp (rd_temp),
        .cs_n    (temp_cs_n),
        .sclk    (temp_sclk)
    );

endmodule

// ==== design/bd_temp_monitor.sv ====
`timescale 1ns/100ps

module bd_temp_monitor
#(
    parameter int SAMPLE_INTERVAL = 4800000
)
(
    input  logic             MCLK,
    input  logic             MRST,
    input  logic             en,
    input  bd_pkg::temp_sw_t temp_sw,
    input  logic             force_start,
    input  logic             rd_ack,
    input  bd_pkg::temp_t    rd_temp,
    output logic             rd_req,
    output logic             delaying,
    output logic             temp_lo_n,
    output logic             fan_en_n
);

    import bd_pkg::*;

    localparam int TMR_W = $clog2(SAMPLE_INTERVAL + 1);

    logic [TMR_W-1:0] interval_tmr;
    logic             have_read;
    temp_t            temp_q;
    logic             is_lo;
    logic             is_hot;

    assign is_lo  = temp_q < warm_threshold[temp_sw];
    assign is_hot = temp_q >= fan_on_temp;

    //////////////////////////////////////////////////////////////////////
    // interval timer and handshake

    always_ff @(posedge MCLK)
    begin
        if (MRST || !en)
        begin
            rd_req       <= 1'b0;
            interval_tmr <= '0;
            have_read    <= 1'b0;
        end
        else if (rd_req)
        begin
            // reading is taken while ack is high, then req drops
            if (rd_ack)
            begin
                rd_req       <= 1'b0;
                have_read    <= 1'b1;
                interval_tmr <= TMR_W'(SAMPLE_INTERVAL - 1);
            end
        end
        else if (!rd_ack)
        begin
            if (interval_tmr == '0)
                rd_req <= 1'b1;
            else
                interval_tmr <= interval_tmr - 1'b1;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (rd_req && rd_ack)
            temp_q <= rd_temp;
    end

    //////////////////////////////////////////////////////////////////////
    // threshold compare and warm-up delay

    always_ff @(posedge MCLK)
    begin
        if (MRST || !en)
        begin
            delaying  <= 1'b1;
            temp_lo_n <= 1'b1;
            fan_en_n  <= 1'b1;
        end
        else
        begin
            if (have_read)
            begin
                temp_lo_n <= ~is_lo;
                fan_en_n  <= ~is_hot;
            end

            // manual override skips the warm-up wait
            if (force_start)
                delaying <= 1'b0;
            else if (have_read)
                delaying <= is_lo;
        end
    end

endmodule

// ==== design/bd_temp_reader.sv ====
`timescale 1ns/100ps

module bd_temp_reader
#(
    parameter int SPI_DIV = 12
)
(
    input  logic          MCLK,
    input  logic          MRST,
    input  logic          rd_req,
    input  logic          sio,
    output logic          rd_ack,
    output bd_pkg::temp_t rd_temp,
    output logic          cs_n,
    output logic          sclk
);

    localparam int DIV_W = $clog2(SPI_DIV + 1);

    typedef enum logic [2:0] {
        idle,
        setup,
        shift,
        done,
        wait_drop
    } rd_state_t;

    rd_state_t        state;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    logic [15:0]      shreg;
    logic             sclk_tick;

    // end of a half sclk period
    assign sclk_tick = (state == shift) && (div_cnt == DIV_W'(SPI_DIV - 1));

    //////////////////////////////////////////////////////////////////////
    // serial read sequencer

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            state   <= idle;
            div_cnt <= '0;
            bit_cnt <= '0;
            rd_ack  <= 1'b0;
            cs_n    <= 1'b1;
            sclk    <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (rd_req)
                    begin
                        cs_n  <= 1'b0;
                        state <= setup;
                    end
                end
                // one clock of cs setup before the first sclk edge
                setup:
                begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= shift;
                end
                shift:
                begin
                    if (sclk_tick)
                    begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        // falling edge closes a bit
                        if (sclk)
                        begin
                            if (bit_cnt == 4'd15)
                            begin
                                cs_n  <= 1'b1;
                                state <= done;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                done:
                begin
                    rd_ack <= 1'b1;
                    state  <= wait_drop;
                end
                wait_drop:
                begin
                    if (!rd_req)
                    begin
                        rd_ack <= 1'b0;
                        state  <= idle;
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data capture, msb first on sclk rising

    always_ff @(posedge MCLK)
    begin
        if (sclk_tick && !sclk)
            shreg <= {shreg[14:0], sio};
        // low three status bits are dropped
        if (state == done)
            rd_temp <= shreg[15:3];
    end

endmodule

// ==== design/bd_mode_ctrl.sv ====
`timescale 1ns/100ps

module bd_mode_ctrl
(
    input  logic             MCLK,
    input  logic             MRST,
    input  logic             usb_pwr,
    input  logic             board_pwr_fail,
    input  logic             delaying,
    input  logic             blink,
    input  logic             acc_n,
    output logic             emu_en,
    output logic             usb_en,
    output logic             temp_en,
    output logic             emu_ready,
    output logic             blink_run,
    output bd_pkg::led_bus_t leds
);

    import bd_pkg::*;

    board_mode_t state;
    logic [1:0]  pwr_sel;

    // led controls, low means lit
    logic        pwrok_ctrl_n;
    logic        standby_ctrl_n;
    logic        delaying_ctrl_n;

    // warm-up only counts while the monitor runs
    logic        warmup_active;

    assign pwr_sel = {usb_pwr, board_pwr_fail};

    //////////////////////////////////////////////////////////////////////
    // startup state machine

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            state <= st_reset;
        end
        else
        begin
            case (state)
                st_reset:
                begin
                    state <= st_select;
                end
                st_select:
                begin
                    case (pwr_sel)
                        2'b00:   state <= st_emulate;
                        2'b01:   state <= st_err_board;
                        2'b10:   state <= st_err_supply;
                        default: state <= st_usb_standby;
                    endcase
                end
                // emulation is left only through reset
                st_emulate:
                begin
                    state <= st_emulate;
                end
                st_usb_standby:
                begin
                    if (pwr_sel != 2'b11)
                        state <= st_reset;
                end
                st_err_board:
                begin
                    if (pwr_sel != 2'b01)
                        state <= st_reset;
                end
                st_err_supply:
                begin
                    if (pwr_sel != 2'b10)
                        state <= st_reset;
                end
                default:
                begin
                    state <= st_reset;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered enables and led controls

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            emu_en          <= 1'b0;
            usb_en          <= 1'b0;
            temp_en         <= 1'b0;
            blink_run       <= 1'b0;
            pwrok_ctrl_n    <= 1'b1;
            standby_ctrl_n  <= 1'b1;
            delaying_ctrl_n <= 1'b1;
        end
        else
        begin
            // everything off unless the state says otherwise
            emu_en          <= 1'b0;
            usb_en          <= 1'b0;
            temp_en         <= 1'b0;
            blink_run       <= 1'b0;
            pwrok_ctrl_n    <= 1'b1;
            standby_ctrl_n  <= 1'b1;
            delaying_ctrl_n <= 1'b1;

            case (state)
                st_emulate:
                begin
                    emu_en          <= 1'b1;
                    usb_en          <= 1'b1;
                    temp_en         <= 1'b1;
                    delaying_ctrl_n <= 1'b0;
                end
                st_usb_standby:
                begin
                    usb_en         <= 1'b1;
                    blink_run      <= 1'b1;
                    pwrok_ctrl_n   <= 1'b0;
                    standby_ctrl_n <= 1'b0;
                end
                st_err_board:
                begin
                    blink_run    <= 1'b1;
                    pwrok_ctrl_n <= 1'b0;
                end
                // pwrok stays dark while standby flashes
                st_err_supply:
                begin
                    blink_run      <= 1'b1;
                    standby_ctrl_n <= 1'b0;
                end
                default:
                begin
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs

    assign emu_ready     = emu_en & ~delaying;
    assign warmup_active = delaying & temp_en;

    always_comb
    begin
        leds.led_acc_n      = acc_n;
        leds.led_delaying_n = delaying_ctrl_n | ~delaying;
        leds.led_standby_n  = (standby_ctrl_n | blink) & ~warmup_active;
        leds.led_pwrok_n    = pwrok_ctrl_n | blink;
    end

endmodule

// ==== design/bd_led_blinker.sv ====
`timescale 1ns/100ps

module bd_led_blinker
#(
    parameter int BLINK_HALF = 48000000
)
(
    input  logic MCLK,
    input  logic MRST,
    input  logic run,
    output logic blink
);

    localparam int CNT_W = $clog2(BLINK_HALF + 1);

    logic [CNT_W-1:0] half_cnt;

    // idle level is high, so an led driven by blink stays dark
    always_ff @(posedge MCLK)
    begin
        if (MRST || !run)
        begin
            half_cnt <= '0;
            blink    <= 1'b1;
        end
        else if (half_cnt == CNT_W'(BLINK_HALF - 1))
        begin
            half_cnt <= '0;
            blink    <= ~blink;
        end
        else
        begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

// ==== design/bd_pkg.sv ====
package bd_pkg;

    //////////////////////////////////////////////////////////////////////
    // startup modes

    typedef enum logic [2:0] {
        st_reset,
        st_select,
        st_emulate,
        st_usb_standby,
        st_err_board,
        st_err_supply
    } board_mode_t;

    //////////////////////////////////////////////////////////////////////
    // temperature sensor

    // signed reading, 1/16 degree per lsb
    typedef logic signed [12:0] temp_t;

    // warm-up threshold switch setting
    typedef logic [2:0] temp_sw_t;

    // warm-up threshold per switch setting, 0 to 35 degrees
    localparam temp_t warm_threshold [0:7] = '{
        13'sd0,
        13'sd80,
        13'sd160,
        13'sd240,
        13'sd320,
        13'sd400,
        13'sd480,
        13'sd560
    };

    // fan runs at or above 40 degrees
    localparam temp_t fan_on_temp = 13'sd640;

    //////////////////////////////////////////////////////////////////////
    // status leds, all active low

    typedef struct packed {
        logic led_acc_n;
        logic led_delaying_n;
        logic led_standby_n;
        logic led_pwrok_n;
    } led_bus_t;

endpackage
